// ==== hw/dvp_reg_pkg.sv ====
`default_nettype none

package dvp_reg_pkg;

    // Word indices on the register bus
    localparam logic [3:0] reg_vi_cr        = 4'd0;
    localparam logic [3:0] reg_vi_sr        = 4'd1;
    localparam logic [3:0] reg_vp_cr        = 4'd2;
    localparam logic [3:0] reg_vp_sr        = 4'd3;
    localparam logic [3:0] reg_vp_start     = 4'd4;
    localparam logic [3:0] reg_vp_end       = 4'd5;
    localparam logic [3:0] reg_vp_scaler    = 4'd6;
    localparam logic [3:0] reg_vp_threshold = 4'd7;
    localparam logic [3:0] reg_vo_cr        = 4'd8;
    localparam logic [3:0] reg_vo_sr        = 4'd9;
    localparam logic [3:0] reg_last         = 4'd9;  // Highest mapped index

    // Control word fields
    localparam int bit_en    = 0;   // Enable, same spot in every CR
    localparam int mode_lsb  = 1;   // VI and VO mode in bits 2:1
    localparam int mode_w    = 2;
    localparam int vp_thr_en = 1;   // Threshold enable in VP_CR

    // Mode codes
    localparam logic [1:0] vi_mode_test = 2'd0;
    localparam logic [1:0] vi_mode_ext  = 2'd1;
    localparam logic [1:0] vo_mode_rgb  = 2'd0;
    localparam logic [1:0] vo_mode_lcd  = 2'd1;

    // Window word layout, x low and y high
    localparam int coord_w = 12;
    localparam int x_lsb   = 0;
    localparam int y_lsb   = 16;

endpackage

`default_nettype wire

// ==== hw/dvp_video_pkg.sv ====
`default_nettype none

package dvp_video_pkg;

    localparam int pix_w = 16;

    // Small frame to keep simulation short
    localparam int h_act   = 32;
    localparam int h_total = 40;
    localparam int v_act   = 8;
    localparam int v_total = 10;

    // RGB565 layout
    localparam int red_msb   = 15;
    localparam int red_lsb   = 11;
    localparam int green_msb = 10;
    localparam int green_lsb = 5;
    localparam int blue_msb  = 4;
    localparam int blue_lsb  = 0;

    localparam int lcd_w = 6;   // One LCD colour channel

    localparam int cnt_w = 16;  // Frame and pixel counters

endpackage

`default_nettype wire

// ==== hw/dvp_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module dvp_regs (
    input  logic        io_ahb_PCLK,
    input  logic        io_ahb_PRESET,
    input  logic        io_ahb_PSEL,
    input  logic        io_ahb_PENABLE,
    input  logic        io_ahb_PWRITE,
    input  logic [3:0]  io_ahb_PADDR,
    input  logic [31:0] io_ahb_PWDATA,
    output logic        io_ahb_PREADY,
    output logic [31:0] io_ahb_PRDATA,
    output logic        io_ahb_PSLVERROR,
    output logic        vi_en,
    output logic [1:0]  vi_mode,
    output logic        vp_en,
    output logic        thr_en,
    output logic [31:0] win_start,
    output logic [31:0] win_end,
    output logic [5:0]  threshold,
    output logic        vo_en,
    output logic [1:0]  vo_mode,
    input  logic [dvp_video_pkg::cnt_w-1:0] frame_cnt,
    input  logic [dvp_video_pkg::cnt_w-1:0] pix_cnt
);

    logic [31:0] vi_cr;
    logic [31:0] vp_cr;
    logic [31:0] vp_start;
    logic [31:0] vp_end;
    logic [31:0] vp_scaler;     // Readable only
    logic [31:0] vp_threshold;
    logic [31:0] vo_cr;
    logic [31:0] vo_sr;
    logic        access;
    logic        is_sr;
    logic        wr;

    assign access = io_ahb_PSEL && io_ahb_PENABLE;
    assign is_sr  = (io_ahb_PADDR == dvp_reg_pkg::reg_vi_sr) ||
                    (io_ahb_PADDR == dvp_reg_pkg::reg_vp_sr) ||
                    (io_ahb_PADDR == dvp_reg_pkg::reg_vo_sr);

    assign io_ahb_PREADY    = 1'b1;  // Single-cycle access
    assign io_ahb_PSLVERROR = access && ((io_ahb_PADDR > dvp_reg_pkg::reg_last) ||
                                         (io_ahb_PWRITE && is_sr));
    assign wr = access && io_ahb_PWRITE && !io_ahb_PSLVERROR;

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            vi_cr        <= '0;
            vp_cr        <= '0;
            vp_start     <= '0;
            vp_end       <= '0;
            vp_scaler    <= '0;
            vp_threshold <= '0;
            vo_cr        <= '0;
        end else if (wr) begin
            case (io_ahb_PADDR)
                dvp_reg_pkg::reg_vi_cr:        vi_cr        <= io_ahb_PWDATA;
                dvp_reg_pkg::reg_vp_cr:        vp_cr        <= io_ahb_PWDATA;
                dvp_reg_pkg::reg_vp_start:     vp_start     <= io_ahb_PWDATA;
                dvp_reg_pkg::reg_vp_end:       vp_end       <= io_ahb_PWDATA;
                dvp_reg_pkg::reg_vp_scaler:    vp_scaler    <= io_ahb_PWDATA;
                dvp_reg_pkg::reg_vp_threshold: vp_threshold <= io_ahb_PWDATA;
                dvp_reg_pkg::reg_vo_cr:        vo_cr        <= io_ahb_PWDATA;
                default: ;
            endcase
        end
    end

    // Output stage status mirrors the live control fields
    always_comb begin
        vo_sr = '0;
        vo_sr[dvp_reg_pkg::bit_en] = vo_en;
        vo_sr[dvp_reg_pkg::mode_lsb +: dvp_reg_pkg::mode_w] = vo_mode;
    end

    always_comb begin
        io_ahb_PRDATA = '0;
        if (access && !io_ahb_PWRITE) begin
            case (io_ahb_PADDR)
                dvp_reg_pkg::reg_vi_cr:        io_ahb_PRDATA = vi_cr;
                dvp_reg_pkg::reg_vi_sr:        io_ahb_PRDATA = 32'(frame_cnt);
                dvp_reg_pkg::reg_vp_cr:        io_ahb_PRDATA = vp_cr;
                dvp_reg_pkg::reg_vp_sr:        io_ahb_PRDATA = 32'(pix_cnt);
                dvp_reg_pkg::reg_vp_start:     io_ahb_PRDATA = vp_start;
                dvp_reg_pkg::reg_vp_end:       io_ahb_PRDATA = vp_end;
                dvp_reg_pkg::reg_vp_scaler:    io_ahb_PRDATA = vp_scaler;
                dvp_reg_pkg::reg_vp_threshold: io_ahb_PRDATA = vp_threshold;
                dvp_reg_pkg::reg_vo_cr:        io_ahb_PRDATA = vo_cr;
                dvp_reg_pkg::reg_vo_sr:        io_ahb_PRDATA = vo_sr;
                default:                       io_ahb_PRDATA = '0;
            endcase
        end
    end

    // Field split, stages only see meaningful bits
    assign vi_en     = vi_cr[dvp_reg_pkg::bit_en];
    assign vi_mode   = vi_cr[dvp_reg_pkg::mode_lsb +: dvp_reg_pkg::mode_w];
    assign vp_en     = vp_cr[dvp_reg_pkg::bit_en];
    assign thr_en    = vp_cr[dvp_reg_pkg::vp_thr_en];
    assign win_start = vp_start;
    assign win_end   = vp_end;
    assign threshold = vp_threshold[5:0];
    assign vo_en     = vo_cr[dvp_reg_pkg::bit_en];
    assign vo_mode   = vo_cr[dvp_reg_pkg::mode_lsb +: dvp_reg_pkg::mode_w];

endmodule

`default_nettype wire

// ==== hw/dvp_vi.sv ====
`timescale 1ns/1ns
`default_nettype none

module dvp_vi (
    input  logic                             io_ahb_PCLK,
    input  logic                             io_ahb_PRESET,
    input  logic                             vi_en,
    input  logic [1:0]                       vi_mode,
    input  logic                             vin_vs,
    input  logic                             vin_de,
    input  logic [dvp_video_pkg::pix_w-1:0]  vin_data,
    output logic                             vi_vs,
    output logic                             vi_de,
    output logic [dvp_video_pkg::pix_w-1:0]  vi_data,
    output logic [dvp_video_pkg::cnt_w-1:0]  frame_cnt
);

    logic [7:0] col;    // Raster column
    logic [7:0] line;   // Raster line
    logic       run_tst;
    logic       tst_de;
    logic       tst_vs;
    logic       vs_q;

    assign run_tst = vi_en && (vi_mode == dvp_reg_pkg::vi_mode_test);
    assign tst_de  = (col < dvp_video_pkg::h_act) && (line < dvp_video_pkg::v_act);
    assign tst_vs  = line == 8'(dvp_video_pkg::v_total - 1);  // Whole last line

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            col  <= '0;
            line <= '0;
        end else if (!run_tst) begin
            col  <= '0;  // Restart raster from the top
            line <= '0;
        end else if (col == 8'(dvp_video_pkg::h_total - 1)) begin
            col  <= '0;
            line <= tst_vs ? 8'd0 : line + 8'd1;
        end else begin
            col <= col + 8'd1;
        end
    end

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            vi_vs   <= 1'b0;
            vi_de   <= 1'b0;
            vi_data <= '0;
        end else if (!vi_en) begin
            vi_vs   <= 1'b0;
            vi_de   <= 1'b0;
            vi_data <= '0;
        end else begin
            case (vi_mode)
                dvp_reg_pkg::vi_mode_test: begin
                    vi_vs   <= tst_vs;
                    vi_de   <= tst_de;
                    vi_data <= tst_de ? {line, col} : '0;  // Line high, column low
                end
                dvp_reg_pkg::vi_mode_ext: begin
                    vi_vs   <= vin_vs;
                    vi_de   <= vin_de;
                    vi_data <= vin_data;
                end
                default: begin
                    vi_vs   <= 1'b0;
                    vi_de   <= 1'b0;
                    vi_data <= '0;
                end
            endcase
        end
    end

    // Frames seen on our own vs, saturating
    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            vs_q      <= 1'b0;
            frame_cnt <= '0;
        end else begin
            vs_q <= vi_vs;
            if (vi_en && vi_vs && !vs_q && (frame_cnt != '1))
                frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dvp_vp.sv ====
`timescale 1ns/1ns
`default_nettype none

module dvp_vp (
    input  logic                             io_ahb_PCLK,
    input  logic                             io_ahb_PRESET,
    input  logic                             vp_en,
    input  logic                             thr_en,
    input  logic [31:0]                      win_start,
    input  logic [31:0]                      win_end,
    input  logic [5:0]                       threshold,
    input  logic                             vi_vs,
    input  logic                             vi_de,
    input  logic [dvp_video_pkg::pix_w-1:0]  vi_data,
    output logic                             vp_vs,
    output logic                             vp_de,
    output logic [dvp_video_pkg::pix_w-1:0]  vp_data,
    output logic [dvp_video_pkg::cnt_w-1:0]  pix_cnt
);

    logic [dvp_reg_pkg::coord_w-1:0] col;
    logic [dvp_reg_pkg::coord_w-1:0] line;
    logic [dvp_reg_pkg::coord_w-1:0] sx, sy, ex, ey;
    logic [dvp_video_pkg::cnt_w-1:0] acc;  // Pixels passed this frame
    logic                            de_q;
    logic                            in_win;
    logic                            pass;
    logic                            hit;

    assign sx = win_start[dvp_reg_pkg::x_lsb +: dvp_reg_pkg::coord_w];
    assign sy = win_start[dvp_reg_pkg::y_lsb +: dvp_reg_pkg::coord_w];
    assign ex = win_end[dvp_reg_pkg::x_lsb +: dvp_reg_pkg::coord_w];
    assign ey = win_end[dvp_reg_pkg::y_lsb +: dvp_reg_pkg::coord_w];

    // Inclusive window on both axes
    assign in_win = (col >= sx) && (col <= ex) && (line >= sy) && (line <= ey);
    assign pass   = vi_de && (!vp_en || in_win);
    assign hit    = vi_data[dvp_video_pkg::green_msb:dvp_video_pkg::green_lsb] >= threshold;

    // Position of the pixel now on the input
    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            col  <= '0;
            line <= '0;
            de_q <= 1'b0;
        end else begin
            de_q <= vi_de;
            col  <= vi_de ? col + 1'b1 : '0;
            if (vi_vs)
                line <= '0;
            else if (de_q && !vi_de)
                line <= line + 1'b1;    // End of an active line
        end
    end

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            vp_vs   <= 1'b0;
            vp_de   <= 1'b0;
            vp_data <= '0;
        end else begin
            vp_vs <= vi_vs;
            vp_de <= pass;
            if (!pass)
                vp_data <= '0;
            else if (vp_en && thr_en)
                vp_data <= hit ? '1 : '0;
            else
                vp_data <= vi_data;
        end
    end

    // vp_vs is last cycle's vi_vs, so this catches the input vs edge
    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            acc     <= '0;
            pix_cnt <= '0;
        end else if (vi_vs && !vp_vs) begin
            pix_cnt <= acc;
            acc     <= '0;
        end else if (pass) begin
            acc <= acc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dvp_vo.sv ====
`timescale 1ns/1ns
`default_nettype none

module dvp_vo (
    input  logic                             io_ahb_PCLK,
    input  logic                             io_ahb_PRESET,
    input  logic                             vo_en,
    input  logic [1:0]                       vo_mode,
    input  logic                             vp_vs,
    input  logic                             vp_de,
    input  logic [dvp_video_pkg::pix_w-1:0]  vp_data,
    output logic                             vo_vs,
    output logic                             vo_de,
    output logic [dvp_video_pkg::pix_w-1:0]  vo_data,
    output logic                             lcd_en,
    output logic [dvp_video_pkg::lcd_w-1:0]  lcd_r,
    output logic [dvp_video_pkg::lcd_w-1:0]  lcd_g,
    output logic [dvp_video_pkg::lcd_w-1:0]  lcd_b
);

    logic on_rgb;
    logic on_lcd;

    assign on_rgb = vo_en && (vo_mode == dvp_reg_pkg::vo_mode_rgb);
    assign on_lcd = vo_en && (vo_mode == dvp_reg_pkg::vo_mode_lcd);

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            vo_vs   <= 1'b0;
            vo_de   <= 1'b0;
            vo_data <= '0;
            lcd_en  <= 1'b0;
            lcd_r   <= '0;
            lcd_g   <= '0;
            lcd_b   <= '0;
        end else begin
            vo_vs   <= on_rgb && vp_vs;
            vo_de   <= on_rgb && vp_de;
            vo_data <= on_rgb ? vp_data : '0;
            lcd_en  <= on_lcd && vp_de;
            // 5-bit channels widened by repeating their MSB
            lcd_r <= on_lcd ? {vp_data[dvp_video_pkg::red_msb:dvp_video_pkg::red_lsb],
                               vp_data[dvp_video_pkg::red_msb]} : '0;
            lcd_g <= on_lcd ? vp_data[dvp_video_pkg::green_msb:dvp_video_pkg::green_lsb] : '0;
            lcd_b <= on_lcd ? {vp_data[dvp_video_pkg::blue_msb:dvp_video_pkg::blue_lsb],
                               vp_data[dvp_video_pkg::blue_msb]} : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dvp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dvp_top (
    input  logic                             io_ahb_PCLK,
    input  logic                             io_ahb_PRESET,
    input  logic                             io_ahb_PSEL,
    input  logic                             io_ahb_PENABLE,
    input  logic                             io_ahb_PWRITE,
    input  logic [3:0]                       io_ahb_PADDR,
    input  logic [31:0]                      io_ahb_PWDATA,
    output logic                             io_ahb_PREADY,
    output logic [31:0]                      io_ahb_PRDATA,
    output logic                             io_ahb_PSLVERROR,
    input  logic                             vin_vs,
    input  logic                             vin_de,
    input  logic [dvp_video_pkg::pix_w-1:0]  vin_data,
    output logic                             vo_vs,
    output logic                             vo_de,
    output logic [dvp_video_pkg::pix_w-1:0]  vo_data,
    output logic                             lcd_en,
    output logic [dvp_video_pkg::lcd_w-1:0]  lcd_r,
    output logic [dvp_video_pkg::lcd_w-1:0]  lcd_g,
    output logic [dvp_video_pkg::lcd_w-1:0]  lcd_b
);

    // Control from the register block
    logic        vi_en, vp_en, thr_en, vo_en;
    logic [1:0]  vi_mode, vo_mode;
    logic [31:0] win_start, win_end;
    logic [5:0]  threshold;

    // Status back to the register block
    logic [dvp_video_pkg::cnt_w-1:0] frame_cnt, pix_cnt;

    // Stream between stages
    logic                            vi_vs, vi_de, vp_vs, vp_de;
    logic [dvp_video_pkg::pix_w-1:0] vi_data, vp_data;

    dvp_regs u_regs (
        .io_ahb_PCLK, .io_ahb_PRESET, .io_ahb_PSEL, .io_ahb_PENABLE, .io_ahb_PWRITE,
        .io_ahb_PADDR, .io_ahb_PWDATA, .io_ahb_PREADY, .io_ahb_PRDATA, .io_ahb_PSLVERROR,
        .vi_en, .vi_mode, .vp_en, .thr_en, .win_start, .win_end, .threshold,
        .vo_en, .vo_mode, .frame_cnt, .pix_cnt
    );

    dvp_vi u_vi (
        .io_ahb_PCLK, .io_ahb_PRESET, .vi_en, .vi_mode,
        .vin_vs, .vin_de, .vin_data,
        .vi_vs, .vi_de, .vi_data, .frame_cnt
    );

    dvp_vp u_vp (
        .io_ahb_PCLK, .io_ahb_PRESET, .vp_en, .thr_en, .win_start, .win_end, .threshold,
        .vi_vs, .vi_de, .vi_data,
        .vp_vs, .vp_de, .vp_data, .pix_cnt
    );

    dvp_vo u_vo (
        .io_ahb_PCLK, .io_ahb_PRESET, .vo_en, .vo_mode,
        .vp_vs, .vp_de, .vp_data,
        .vo_vs, .vo_de, .vo_data, .lcd_en, .lcd_r, .lcd_g, .lcd_b
    );

endmodule

`default_nettype wire

// ==== verification/dvp_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dvp_tb;

    localparam int half_period = 10;
    localparam int h_act       = dvp_video_pkg::h_act;
    localparam int v_act       = dvp_video_pkg::v_act;
    localparam int h_total     = dvp_video_pkg::h_total;
    localparam int v_total     = dvp_video_pkg::v_total;
    localparam int frames_run  = 8;                                  // Frames over all tests
    localparam int wd_cycles   = (frames_run + 4) * h_total * v_total;  // Plus setup margin

    logic                             io_ahb_PCLK;
    logic                             io_ahb_PRESET;
    logic                             io_ahb_PSEL;
    logic                             io_ahb_PENABLE;
    logic                             io_ahb_PWRITE;
    logic [3:0]                       io_ahb_PADDR;
    logic [31:0]                      io_ahb_PWDATA;
    logic                             io_ahb_PREADY;
    logic [31:0]                      io_ahb_PRDATA;
    logic                             io_ahb_PSLVERROR;
    logic                             vin_vs;
    logic                             vin_de;
    logic [dvp_video_pkg::pix_w-1:0]  vin_data;
    logic                             vo_vs;
    logic                             vo_de;
    logic [dvp_video_pkg::pix_w-1:0]  vo_data;
    logic                             lcd_en;
    logic [dvp_video_pkg::lcd_w-1:0]  lcd_r;
    logic [dvp_video_pkg::lcd_w-1:0]  lcd_g;
    logic [dvp_video_pkg::lcd_w-1:0]  lcd_b;

    int          errors      = 0;
    int          chk         = 0;   // 0 idle, 1 test pattern, 2 delay line, 3 all quiet
    int          pix_idx     = 0;
    int          frames_seen = 0;
    int          sx          = 0;   // Window model, inclusive
    int          sy          = 0;
    int          ex          = h_act - 1;
    int          ey          = v_act - 1;
    logic        m_vp_en     = 1'b0;
    logic        m_thr_en    = 1'b0;
    logic        m_lcd       = 1'b0;
    logic [5:0]  m_thr       = '0;
    logic        vs_q        = 1'b0;
    logic        cur_vs      = 1'b0;  // Expected VP output for the pixel now on vin
    logic        cur_de      = 1'b0;
    logic [15:0] cur_data    = '0;
    logic [2:0]  dl_vs;
    logic [2:0]  dl_de;
    logic [15:0] dl_data [3];

    dvp_top u_dvp_top (
        .io_ahb_PCLK, .io_ahb_PRESET, .io_ahb_PSEL, .io_ahb_PENABLE, .io_ahb_PWRITE,
        .io_ahb_PADDR, .io_ahb_PWDATA, .io_ahb_PREADY, .io_ahb_PRDATA, .io_ahb_PSLVERROR,
        .vin_vs, .vin_de, .vin_data,
        .vo_vs, .vo_de, .vo_data, .lcd_en, .lcd_r, .lcd_g, .lcd_b
    );

    initial io_ahb_PCLK = 1'b0;
    always #half_period io_ahb_PCLK = ~io_ahb_PCLK;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    function automatic logic [31:0] ctrl_word(input logic en, input logic [1:0] mode);
        ctrl_word = '0;
        ctrl_word[dvp_reg_pkg::bit_en] = en;
        ctrl_word[dvp_reg_pkg::mode_lsb +: dvp_reg_pkg::mode_w] = mode;
    endfunction

    // Setup cycle, access cycle, sample mid access
    task automatic bus_cycle(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        @(posedge io_ahb_PCLK);
        #2;
        io_ahb_PSEL   = 1'b1;
        io_ahb_PWRITE = wr;
        io_ahb_PADDR  = addr;
        io_ahb_PWDATA = wdata;
        @(posedge io_ahb_PCLK);
        #2;
        io_ahb_PENABLE = 1'b1;
        @(negedge io_ahb_PCLK);
        rdata = io_ahb_PRDATA;
        err   = io_ahb_PSLVERROR;
        @(posedge io_ahb_PCLK);
        #2;
        io_ahb_PSEL    = 1'b0;
        io_ahb_PENABLE = 1'b0;
        io_ahb_PWRITE  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        bus_cycle(1'b1, addr, data, rdata, err);
        assert (err == exp_err) else report_mismatch("io_ahb_PSLVERROR", 32'(err), 32'(exp_err));
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        bus_cycle(1'b0, addr, '0, rdata, err);
        assert (err == exp_err) else report_mismatch("io_ahb_PSLVERROR", 32'(err), 32'(exp_err));
        assert (rdata == exp) else report_mismatch("io_ahb_PRDATA", rdata, exp);
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        logic err;
        bus_cycle(1'b0, addr, '0, data, err);
        assert (!err) else report_failure("register read raised io_ahb_PSLVERROR");
    endtask

    // Test raster for n frames, stopped inside the vs line so VP restarts at line 0
    task automatic run_pattern(input int n);
        int target;
        pix_idx = 0;
        target  = frames_seen + n;
        chk     = 1;
        write_reg(dvp_reg_pkg::reg_vi_cr, ctrl_word(1'b1, dvp_reg_pkg::vi_mode_test), 1'b0);
        while (frames_seen < target)
            @(posedge io_ahb_PCLK);
        write_reg(dvp_reg_pkg::reg_vi_cr, '0, 1'b0);
        repeat (4) @(posedge io_ahb_PCLK);
        chk = 0;
    endtask

    // External raster with random data; expected VP output built alongside
    task automatic drive_frames(input int n);
        int          f;
        int          x;
        int          y;
        logic        pass;
        logic [15:0] d;
        for (f = 0; f < n; f++) begin
            for (y = 0; y < v_total; y++) begin
                for (x = 0; x < h_total; x++) begin
                    @(posedge io_ahb_PCLK);
                    #2;
                    d        = 16'($urandom);
                    vin_vs   = (y == v_total - 1);
                    vin_de   = (x < h_act) && (y < v_act);
                    vin_data = d;
                    pass = vin_de && (!m_vp_en || (x >= sx && x <= ex && y >= sy && y <= ey));
                    cur_vs = vin_vs;
                    cur_de = pass;
                    if (!pass)
                        cur_data = '0;
                    else if (m_vp_en && m_thr_en)
                        cur_data = (d[10:5] >= m_thr) ? 16'hffff : 16'h0000;
                    else
                        cur_data = d;
                end
            end
        end
        @(posedge io_ahb_PCLK);
        #2;
        vin_vs   = 1'b0;
        vin_de   = 1'b0;
        vin_data = '0;
        cur_vs   = 1'b0;
        cur_de   = 1'b0;
        cur_data = '0;
        repeat (4) @(posedge io_ahb_PCLK);  // Drain the three stages
    endtask

    // Window pixels in raster order, {line, column}
    task automatic check_pattern();
        int          w;
        logic [15:0] exp;
        w = ex - sx + 1;
        if (vo_vs && !vs_q) begin
            assert (pix_idx == w * (ey - sy + 1))
                else report_mismatch("pixels per frame", 32'(pix_idx), 32'(w * (ey - sy + 1)));
            frames_seen++;
            pix_idx = 0;
        end
        if (vo_de) begin
            exp = {8'(sy + pix_idx / w), 8'(sx + pix_idx % w)};
            assert (vo_data == exp) else report_mismatch("vo_data", 32'(vo_data), 32'(exp));
            pix_idx++;
        end
        assert (!lcd_en) else report_failure("lcd_en high in RGB mode");
    endtask

    task automatic check_stream();
        logic [15:0] d;
        d = dl_data[2];
        if (m_lcd) begin
            assert (!vo_vs && !vo_de && vo_data == '0)
                else report_failure("RGB outputs active in LCD mode");
            assert (lcd_en == dl_de[2]) else report_mismatch("lcd_en", 32'(lcd_en), 32'(dl_de[2]));
            assert (lcd_r == {d[15:11], d[15]})
                else report_mismatch("lcd_r", 32'(lcd_r), 32'({d[15:11], d[15]}));
            assert (lcd_g == d[10:5]) else report_mismatch("lcd_g", 32'(lcd_g), 32'(d[10:5]));
            assert (lcd_b == {d[4:0], d[4]})
                else report_mismatch("lcd_b", 32'(lcd_b), 32'({d[4:0], d[4]}));
        end else begin
            assert (vo_vs == dl_vs[2]) else report_mismatch("vo_vs", 32'(vo_vs), 32'(dl_vs[2]));
            assert (vo_de == dl_de[2]) else report_mismatch("vo_de", 32'(vo_de), 32'(dl_de[2]));
            assert (vo_data == d) else report_mismatch("vo_data", 32'(vo_data), 32'(d));
            assert (!lcd_en) else report_failure("lcd_en high in RGB mode");
        end
    endtask

    // Mirrors the three register stages of the DUT
    always @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            dl_vs      <= '0;
            dl_de      <= '0;
            dl_data[0] <= '0;
            dl_data[1] <= '0;
            dl_data[2] <= '0;
        end else begin
            dl_vs      <= {dl_vs[1:0], cur_vs};
            dl_de      <= {dl_de[1:0], cur_de};
            dl_data[0] <= cur_data;
            dl_data[1] <= dl_data[0];
            dl_data[2] <= dl_data[1];
        end
    end

    always @(negedge io_ahb_PCLK) begin
        if (chk == 1)
            check_pattern();
        else if (chk == 2)
            check_stream();
        else if (chk == 3)
            assert ({vo_vs, vo_de, vo_data, lcd_en, lcd_r, lcd_g, lcd_b} == '0)
                else report_failure("outputs not quiet with output stage disabled");
        vs_q = vo_vs;
    end

    assert property (@(posedge io_ahb_PCLK) io_ahb_PREADY)
        else report_failure("io_ahb_PREADY went low");
    assert property (@(posedge io_ahb_PCLK) disable iff (io_ahb_PRESET) !(vo_vs && vo_de))
        else report_failure("vo_de high during vo_vs");
    assert property (@(posedge io_ahb_PCLK) disable iff (io_ahb_PRESET) !(vo_de && lcd_en))
        else report_failure("vo_de and lcd_en high together");

    initial begin
        int          i;
        logic [31:0] wv [10];
        logic [31:0] f0;
        logic [31:0] f1;
        void'($urandom(32'h00e7e2b1));
        io_ahb_PRESET  = 1'b1;
        io_ahb_PSEL    = 1'b0;
        io_ahb_PENABLE = 1'b0;
        io_ahb_PWRITE  = 1'b0;
        io_ahb_PADDR   = '0;
        io_ahb_PWDATA  = '0;
        vin_vs         = 1'b0;
        vin_de         = 1'b0;
        vin_data       = '0;
        repeat (16) @(posedge io_ahb_PCLK);
        #2;
        io_ahb_PRESET = 1'b0;

        for (i = 0; i <= 9; i++)
            check_reg(4'(i), '0, 1'b0);

        // Random contents, enables kept clear so no stream starts
        for (i = 0; i <= 9; i++) begin
            wv[i] = (i == 1 || i == 3 || i == 9) ? 32'h0 : $urandom;
            if (i == 0 || i == 8)
                wv[i][dvp_reg_pkg::bit_en] = 1'b0;
            if (i != 1 && i != 3 && i != 9)
                write_reg(4'(i), wv[i], 1'b0);
        end
        wv[9] = wv[8] & 32'h6;  // Live vo_mode, vo_en
        write_reg(dvp_reg_pkg::reg_vi_sr, '1, 1'b1);
        write_reg(dvp_reg_pkg::reg_vp_sr, '1, 1'b1);
        write_reg(dvp_reg_pkg::reg_vo_sr, '1, 1'b1);
        write_reg(4'(10 + $urandom % 6), '1, 1'b1);
        check_reg(4'(10 + $urandom % 6), '0, 1'b1);
        for (i = 0; i <= 9; i++)
            check_reg(4'(i), wv[i], 1'b0);
        for (i = 0; i <= 8; i++)
            if (i != 1 && i != 3)
                write_reg(4'(i), '0, 1'b0);

        // Test pattern, VP bypass, RGB out
        write_reg(dvp_reg_pkg::reg_vo_cr, ctrl_word(1'b1, dvp_reg_pkg::vo_mode_rgb), 1'b0);
        read_reg(dvp_reg_pkg::reg_vi_sr, f0);
        run_pattern(2);
        read_reg(dvp_reg_pkg::reg_vi_sr, f1);
        assert (f1 - f0 >= 1 && f1 - f0 <= 3)
            else report_failure($sformatf("frame counter moved by %0d over 2 frames", f1 - f0));
        check_reg(dvp_reg_pkg::reg_vp_sr, 32'(h_act * v_act), 1'b0);

        // Random crop window
        sx = $urandom % h_act;
        ex = sx + $urandom % (h_act - sx);
        sy = $urandom % v_act;
        ey = sy + $urandom % (v_act - sy);
        write_reg(dvp_reg_pkg::reg_vp_start, 32'((sy << 16) | sx), 1'b0);
        write_reg(dvp_reg_pkg::reg_vp_end, 32'((ey << 16) | ex), 1'b0);
        write_reg(dvp_reg_pkg::reg_vp_cr, 32'(1 << dvp_reg_pkg::bit_en), 1'b0);
        m_vp_en = 1'b1;
        run_pattern(2);
        check_reg(dvp_reg_pkg::reg_vp_sr, 32'((ex - sx + 1) * (ey - sy + 1)), 1'b0);

        // Threshold on external data, window still applied
        m_thr    = 6'($urandom);
        m_thr_en = 1'b1;
        write_reg(dvp_reg_pkg::reg_vp_threshold, 32'(m_thr), 1'b0);
        write_reg(dvp_reg_pkg::reg_vp_cr,
                  32'((1 << dvp_reg_pkg::bit_en) | (1 << dvp_reg_pkg::vp_thr_en)), 1'b0);
        write_reg(dvp_reg_pkg::reg_vi_cr, ctrl_word(1'b1, dvp_reg_pkg::vi_mode_ext), 1'b0);
        chk = 2;
        drive_frames(2);
        chk = 0;

        // LCD output, then output stage off
        m_vp_en  = 1'b0;
        m_thr_en = 1'b0;
        m_lcd    = 1'b1;
        write_reg(dvp_reg_pkg::reg_vp_cr, '0, 1'b0);
        write_reg(dvp_reg_pkg::reg_vo_cr, ctrl_word(1'b1, dvp_reg_pkg::vo_mode_lcd), 1'b0);
        check_reg(dvp_reg_pkg::reg_vo_sr, ctrl_word(1'b1, dvp_reg_pkg::vo_mode_lcd), 1'b0);
        chk = 2;
        drive_frames(1);
        chk = 0;
        write_reg(dvp_reg_pkg::reg_vo_cr, '0, 1'b0);
        chk = 3;
        drive_frames(1);
        chk = 0;

        $display("Run complete, error count %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        #(wd_cycles * 2 * half_period);
        $display("Timeout after %0d cycles, run did not complete, error count %0d",
                 wd_cycles, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/dvp_reg_pkg.sv
hw/dvp_video_pkg.sv
hw/dvp_regs.sv
hw/dvp_vi.sv
hw/dvp_vp.sv
hw/dvp_vo.sv
hw/dvp_top.sv
verification/dvp_tb.sv
